//--- src.f
+incdir+include
hdl/rv_core_pkg.sv
hdl/rv_fetch.sv
hdl/rv_decode.sv
hdl/rv_execute.sv
hdl/rv_regfile.sv
hdl/rv_lsu.sv
hdl/rv_core.sv
verif/rv_clock_gen.sv
verif/rv_core_properties.sv
verif/rv_core_tb.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -Wno-fatal
TOP       ?= rv_core_tb
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

SIM  := $(OBJ_DIR)/V$(TOP)
SRCS := $(shell grep -v '^+' $(FILELIST)) include/rv_core_consts.svh

.PHONY: all run clean

all: run

$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	-./$(SIM) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "TESTS FAILED" $(LOG); then exit 1; fi
	@if ! grep -q "TESTS PASSED" $(LOG); then exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- verif/rv_core_tb.sv
`timescale 1ns/1ps
`include "rv_core_consts.svh"

module rv_core_tb;
	import rv_core_pkg::*;

	localparam int MAX_ROWS = 32;
	localparam int MEM_WORDS = 64;
	localparam logic [31:0] DATA_BASE = 32'h8000_1000;

	logic clock;
	logic rst_n;
	mem_req_t imem_req;
	logic imem_req_valid;
	logic imem_req_ready;
	logic imem_rsp_valid;
	logic [31:0] imem_rsp_data;
	mem_req_t dmem_req;
	logic dmem_req_valid;
	logic dmem_req_ready;
	logic dmem_rsp_valid;
	logic [31:0] dmem_rsp_data;
	logic commit_valid;
	commit_t commit;

	// program table, one row per expected commit.
	logic [31:0] t_inst [MAX_ROWS];
	logic [31:0] t_pc [MAX_ROWS];
	logic [3:0] t_rd [MAX_ROWS];
	logic t_we [MAX_ROWS];
	logic [31:0] t_wdata [MAX_ROWS];
	logic t_store [MAX_ROWS];
	logic [31:0] t_saddr [MAX_ROWS];
	logic [31:0] t_sdata [MAX_ROWS];
	int nrows = 0;
	int cur_row = 0;
	bit done = 0;
	bit store_seen = 0;

	logic [31:0] imem [MEM_WORDS];
	logic [31:0] dmem [MEM_WORDS];
	integer seed = 32'h3732;
	bit i_pend;
	bit d_pend;
	int i_cnt;
	int d_cnt;
	mem_req_t i_held;
	mem_req_t d_held;

	rv_clock_gen #(.PERIOD(8.0), .RESET_TICKS(4)) clock_i (.clock(clock), .rst_n(rst_n));

	rv_core dut_i (.*);

	function automatic logic [31:0] enc_r(logic [6:0] f7, logic [2:0] f3, logic [4:0] rd,
		logic [4:0] rs1, logic [4:0] rs2);
		return {f7, rs2, rs1, f3, rd, 7'b0110011};
	endfunction

	function automatic logic [31:0] enc_i(logic [6:0] op, logic [2:0] f3, logic [4:0] rd,
		logic [4:0] rs1, logic [11:0] imm);
		return {imm, rs1, f3, rd, op};
	endfunction

	function automatic logic [31:0] enc_s(logic [4:0] rs1, logic [4:0] rs2, logic [11:0] imm);
		return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
	endfunction

	function automatic logic [31:0] enc_b(logic [2:0] f3, logic [4:0] rs1, logic [4:0] rs2,
		logic [12:0] imm);
		return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
	endfunction

	function automatic logic [31:0] enc_j(logic [4:0] rd, logic [20:0] imm);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
	endfunction

	task automatic add_row(logic [31:0] pc, logic [31:0] inst, logic [3:0] rd, logic we,
		logic [31:0] wdata);
		t_pc[nrows] = pc;
		t_inst[nrows] = inst;
		t_rd[nrows] = rd;
		t_we[nrows] = we;
		t_wdata[nrows] = wdata;
		t_store[nrows] = 1'b0;
		nrows++;
	endtask

	task automatic expect_store(logic [31:0] addr, logic [31:0] data);
		t_store[nrows-1] = 1'b1; // applies to the row just added.
		t_saddr[nrows-1] = addr;
		t_sdata[nrows-1] = data;
	endtask

	task automatic report_mismatch(string what);
		$display("FAILED at %0t ns: %s", $time, what);
		$display("TESTS FAILED");
		$fatal(1, "stopping at the first mismatch");
	endtask

	task automatic check_commit(commit_t got, int row);
		if (got.pc !== t_pc[row])
			report_mismatch($sformatf("row %0d pc %h, expected %h", row, got.pc, t_pc[row]));
		if (got.inst !== t_inst[row])
			report_mismatch($sformatf("row %0d inst %h, expected %h", row, got.inst, t_inst[row]));
		if (got.we !== t_we[row])
			report_mismatch($sformatf("row %0d we %b, expected %b", row, got.we, t_we[row]));
		if (t_we[row] && got.rd !== t_rd[row])
			report_mismatch($sformatf("row %0d rd %0d, expected %0d", row, got.rd, t_rd[row]));
		if (t_we[row] && t_rd[row] != 4'd0 && got.wdata !== t_wdata[row])
			report_mismatch($sformatf("row %0d wdata %h, expected %h", row, got.wdata,
				t_wdata[row]));
		if (t_store[row] && !store_seen)
			report_mismatch($sformatf("row %0d committed without its store", row));
	endtask

	task automatic check_store(mem_req_t got, int row);
		if (row >= nrows || !t_store[row])
			report_mismatch($sformatf("unexpected store to %h before row %0d", got.addr, row));
		else if (got.addr !== t_saddr[row] || got.wdata !== t_sdata[row] || got.wstrb !== 4'hf)
			report_mismatch($sformatf("store %h/%h/%h, expected %h/%h/f", got.addr, got.wdata,
				got.wstrb, t_saddr[row], t_sdata[row]));
	endtask

	task automatic check_fetch(mem_req_t got, int row);
		if (got.write !== 1'b0 || got.addr !== t_pc[row])
			report_mismatch($sformatf("fetch addr %h, expected %h", got.addr, t_pc[row]));
	endtask

	// words outside the array read back as the same address pattern as the fill.
	function automatic logic [31:0] load_word(logic [31:0] addr);
		logic [31:0] offset;
		offset = addr - DATA_BASE;
		if (offset < 4 * MEM_WORDS)
			return dmem[offset >> 2];
		else
			return addr ^ 32'h5a5a_a5a5;
	endfunction

	initial begin
		imem_req_ready = 1'b0;
		imem_rsp_valid = 1'b0;
		imem_rsp_data = '0;
		dmem_req_ready = 1'b0;
		dmem_rsp_valid = 1'b0;
		dmem_rsp_data = '0;
		for (int i = 0; i < MEM_WORDS; i++) begin
			imem[i] = (`RV_RESET_PC + 4 * i) ^ 32'hffff_ffff; // illegal if ever fetched.
			dmem[i] = (DATA_BASE + 4 * i) ^ 32'h5a5a_a5a5;
		end
		add_row(32'h8000_0000, {20'h12345, 5'd1, 7'b0110111}, 4'd1, 1'b1, 32'h1234_5000);
		add_row(32'h8000_0004, enc_i(7'b0010011, 3'b000, 5'd2, 5'd0, 12'h7ff), 4'd2, 1'b1,
			32'h0000_07ff);
		add_row(32'h8000_0008, enc_i(7'b0010011, 3'b000, 5'd3, 5'd0, 12'hffb), 4'd3, 1'b1,
			32'hffff_fffb);
		add_row(32'h8000_000c, enc_r(7'h00, 3'b000, 5'd4, 5'd2, 5'd3), 4'd4, 1'b1, 32'h7fa);
		add_row(32'h8000_0010, enc_r(7'h20, 3'b000, 5'd5, 5'd2, 5'd3), 4'd5, 1'b1, 32'h804);
		add_row(32'h8000_0014, enc_r(7'h00, 3'b111, 5'd6, 5'd2, 5'd3), 4'd6, 1'b1, 32'h7fb);
		add_row(32'h8000_0018, enc_r(7'h00, 3'b110, 5'd7, 5'd4, 5'd5), 4'd7, 1'b1, 32'hffe);
		add_row(32'h8000_001c, enc_r(7'h00, 3'b100, 5'd8, 5'd1, 5'd2), 4'd8, 1'b1,
			32'h1234_57ff);
		add_row(32'h8000_0020, enc_i(7'b0010011, 3'b000, 5'd0, 5'd2, 12'h001), 4'd0, 1'b1,
			32'h800);
		add_row(32'h8000_0024, enc_r(7'h00, 3'b000, 5'd9, 5'd0, 5'd0), 4'd9, 1'b1, 32'h0);
		add_row(32'h8000_0028, {20'h80001, 5'd10, 7'b0110111}, 4'd10, 1'b1, DATA_BASE);
		add_row(32'h8000_002c, enc_s(5'd10, 5'd8, 12'h008), 4'd0, 1'b0, 32'h0);
		expect_store(DATA_BASE + 32'h8, 32'h1234_57ff);
		add_row(32'h8000_0030, enc_i(7'b0000011, 3'b010, 5'd11, 5'd10, 12'h008), 4'd11, 1'b1,
			32'h1234_57ff);
		add_row(32'h8000_0034, enc_b(3'b000, 5'd11, 5'd8, 13'd8), 4'd0, 1'b0, 32'h0);
		add_row(32'h8000_003c, enc_b(3'b001, 5'd11, 5'd8, 13'd8), 4'd0, 1'b0, 32'h0);
		add_row(32'h8000_0040, enc_b(3'b001, 5'd2, 5'd3, 13'd12), 4'd0, 1'b0, 32'h0);
		add_row(32'h8000_004c, enc_j(5'd12, 21'd8), 4'd12, 1'b1, 32'h8000_0050);
		add_row(32'h8000_0054, 32'hffff_ffff, 4'd0, 1'b0, 32'h0);
		add_row(32'h8000_0058, enc_i(7'b0010011, 3'b000, 5'd13, 5'd12, 12'h000), 4'd13, 1'b1,
			32'h8000_0050);
		for (int r = 0; r < nrows; r++) begin
			imem[(t_pc[r] - `RV_RESET_PC) >> 2] = t_inst[r];
		end
		for (int r = 0; r < nrows; r++) begin
			do @(negedge clock); while (!commit_valid);
			check_commit(commit, r);
			store_seen = 1'b0;
			cur_row = r + 1;
		end
		done = 1'b1;
		if (dut_i.props_i.fail_count == 0) begin
			$display("TESTS PASSED");
			$finish;
		end else begin
			$display("%0d bus or commit assertions failed", dut_i.props_i.fail_count);
			$display("TESTS FAILED");
			$fatal(1, "assertion failures");
		end
	end

	// requests are checked on the cycle before the accepting edge.
	always @(negedge clock) begin
		if (rst_n && imem_req_valid && imem_req_ready && cur_row < nrows)
			check_fetch(imem_req, cur_row);
		if (rst_n && dmem_req_valid && dmem_req_ready && dmem_req.write) begin
			check_store(dmem_req, cur_row);
			store_seen = 1'b1;
		end
	end

	always @(posedge clock) begin
		if (!rst_n) begin
			i_pend = 1'b0;
		end else begin
			imem_rsp_valid <= 1'b0;
			if (i_pend) begin
				if (i_cnt == 0) begin
					imem_rsp_valid <= 1'b1;
					imem_rsp_data <= imem[((i_held.addr - `RV_RESET_PC) >> 2) % MEM_WORDS];
					i_pend = 1'b0;
				end else begin
					i_cnt--;
				end
			end else if (imem_req_valid && imem_req_ready) begin
				i_held = imem_req;
				i_cnt = $random(seed) & 3; // zero to three extra cycles.
				i_pend = 1'b1;
			end
			imem_req_ready <= $random(seed) & 1;
		end
	end

	always @(posedge clock) begin
		if (!rst_n) begin
			d_pend = 1'b0;
		end else begin
			dmem_rsp_valid <= 1'b0;
			if (d_pend) begin
				if (d_cnt == 0) begin
					dmem_rsp_valid <= 1'b1;
					dmem_rsp_data <= d_held.write ? 32'h0 : load_word(d_held.addr);
					if (d_held.write)
						dmem[(d_held.addr - DATA_BASE) >> 2] = d_held.wdata;
					d_pend = 1'b0;
				end else begin
					d_cnt--;
				end
			end else if (dmem_req_valid && dmem_req_ready) begin
				d_held = dmem_req;
				d_cnt = $random(seed) & 3;
				d_pend = 1'b1;
			end
			dmem_req_ready <= $random(seed) & 1;
		end
	end

	initial begin
		@(posedge rst_n);
		repeat (20 * nrows) @(posedge clock);
		if (!done) begin
			$display("timeout: the core stopped committing instructions");
			$display("TESTS FAILED");
			$fatal(1, "watchdog expired");
		end
	end

endmodule

//--- verif/rv_core_properties.sv
`timescale 1ns/1ps

module rv_core_properties (
	input logic                  clock,
	input logic                  rst_n,
	input rv_core_pkg::mem_req_t imem_req,
	input logic                  imem_req_valid,
	input logic                  imem_req_ready,
	input rv_core_pkg::mem_req_t dmem_req,
	input logic                  dmem_req_valid,
	input logic                  dmem_req_ready,
	input logic                  commit_valid
);

	int unsigned fail_count = 0;

	// a request waiting on ready must not move.
	imem_hold: assert property (@(posedge clock) disable iff (!rst_n)
		imem_req_valid && !imem_req_ready |=> imem_req_valid && $stable(imem_req))
		else begin
			fail_count++;
			$error("instruction request changed while waiting for ready");
		end

	dmem_hold: assert property (@(posedge clock) disable iff (!rst_n)
		dmem_req_valid && !dmem_req_ready |=> dmem_req_valid && $stable(dmem_req))
		else begin
			fail_count++;
			$error("data request changed while waiting for ready");
		end

	quiet_in_reset: assert property (@(posedge clock)
		!rst_n |-> !imem_req_valid && !dmem_req_valid && !commit_valid)
		else begin
			fail_count++;
			$error("core output active during reset");
		end

	single_commit: assert property (@(posedge clock) disable iff (!rst_n)
		commit_valid |=> !commit_valid)
		else begin
			fail_count++;
			$error("commit strobe high on two cycles in a row");
		end

endmodule

bind rv_core rv_core_properties props_i (.*);

//--- verif/rv_clock_gen.sv
`timescale 1ns/1ps

module rv_clock_gen #(
	parameter realtime PERIOD      = 8.0,
	parameter int      RESET_TICKS = 4
) (
	output logic clock,
	output logic rst_n
);

	initial begin
		clock = 1'b0;
		forever #(PERIOD / 2.0) clock = ~clock;
	end

	initial begin
		rst_n = 1'b0;
		repeat (RESET_TICKS) @(posedge clock);
		rst_n <= 1'b1; // released on a rising edge.
	end

endmodule

//--- hdl/rv_core.sv
`timescale 1ns/1ps

module rv_core (
	input  logic                  clock,
	input  logic                  rst_n,
	output rv_core_pkg::mem_req_t imem_req,
	output logic                  imem_req_valid,
	input  logic                  imem_req_ready,
	input  logic                  imem_rsp_valid,
	input  logic [31:0]           imem_rsp_data,
	output rv_core_pkg::mem_req_t dmem_req,
	output logic                  dmem_req_valid,
	input  logic                  dmem_req_ready,
	input  logic                  dmem_rsp_valid,
	input  logic [31:0]           dmem_rsp_data,
	output logic                  commit_valid,
	output rv_core_pkg::commit_t  commit
);
	import rv_core_pkg::*;

	logic [31:0]  pc;
	logic [31:0]  inst;
	logic         inst_valid;
	decoded_t     dec;
	logic [31:0]  src1;
	logic [31:0]  src2;
	exec_result_t result;
	logic         rf_we;
	logic [3:0]   rf_waddr;
	logic [31:0]  rf_wdata;
	logic [31:0]  next_pc;

	rv_fetch fetch_i (
		.clock(clock), .rst_n(rst_n),
		.commit_valid(commit_valid), .next_pc(next_pc),
		.imem_req(imem_req), .imem_req_valid(imem_req_valid), .imem_req_ready(imem_req_ready),
		.imem_rsp_valid(imem_rsp_valid), .imem_rsp_data(imem_rsp_data),
		.pc(pc), .inst(inst), .inst_valid(inst_valid)
	);

	rv_decode decode_i (.inst(inst), .dec(dec));

	rv_regfile regfile_i (
		.clock(clock), .rst_n(rst_n),
		.raddr1(dec.rs1), .raddr2(dec.rs2), .rdata1(src1), .rdata2(src2),
		.we(rf_we), .waddr(rf_waddr), .wdata(rf_wdata)
	);

	rv_execute execute_i (.dec(dec), .pc(pc), .src1(src1), .src2(src2), .result(result));

	rv_lsu lsu_i (
		.clock(clock), .rst_n(rst_n), .inst_valid(inst_valid),
		.pc(pc), .inst(inst), .dec(dec), .result(result), .store_data(src2),
		.dmem_req(dmem_req), .dmem_req_valid(dmem_req_valid), .dmem_req_ready(dmem_req_ready),
		.dmem_rsp_valid(dmem_rsp_valid), .dmem_rsp_data(dmem_rsp_data),
		.rf_we(rf_we), .rf_waddr(rf_waddr), .rf_wdata(rf_wdata),
		.next_pc(next_pc), .commit_valid(commit_valid), .commit(commit)
	);

endmodule

//--- hdl/rv_lsu.sv
`timescale 1ns/1ps

module rv_lsu (
	input  logic                      clock,
	input  logic                      rst_n,
	input  logic                      inst_valid,
	input  logic [31:0]               pc,
	input  logic [31:0]               inst,
	input  rv_core_pkg::decoded_t     dec,
	input  rv_core_pkg::exec_result_t result,
	input  logic [31:0]               store_data,
	output rv_core_pkg::mem_req_t     dmem_req,
	output logic                      dmem_req_valid,
	input  logic                      dmem_req_ready,
	input  logic                      dmem_rsp_valid,
	input  logic [31:0]               dmem_rsp_data,
	output logic                      rf_we,
	output logic [3:0]                rf_waddr,
	output logic [31:0]               rf_wdata,
	output logic [31:0]               next_pc,
	output logic                      commit_valid,
	output rv_core_pkg::commit_t      commit
);
	import rv_core_pkg::*;

	core_state_e  state;
	decoded_t     dec_q;
	exec_result_t result_q;
	logic [31:0]  pc_q;
	logic [31:0]  inst_q;
	logic [31:0]  store_data_q;
	logic [31:0]  load_q;

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			state          <= ST_EXEC;
			dmem_req_valid <= 1'b0;
		end else begin
			case (state)
				ST_EXEC: begin
					if (inst_valid) begin
						if (dec.is_load || dec.is_store) begin
							state          <= ST_MEM;
							dmem_req_valid <= 1'b1;
						end else begin
							state <= ST_COMMIT;
						end
					end
				end
				ST_MEM: begin
					if (dmem_req_valid && dmem_req_ready) begin
						dmem_req_valid <= 1'b0;
					end
					if (dmem_rsp_valid) begin
						state <= ST_COMMIT; // a store response only ends the access.
					end
				end
				default: begin
					state <= ST_EXEC;
				end
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (state == ST_EXEC && inst_valid) begin
			dec_q        <= dec;
			result_q     <= result;
			pc_q         <= pc;
			inst_q       <= inst;
			store_data_q <= store_data;
		end
		if (state == ST_MEM && dmem_rsp_valid) begin
			load_q <= dmem_rsp_data;
		end
	end

	assign dmem_req = '{addr: result_q.mem_addr, wdata: store_data_q,
		wstrb: dec_q.is_store ? 4'hf : 4'h0, write: dec_q.is_store};

	assign commit_valid = (state == ST_COMMIT);
	assign rf_we        = commit_valid & dec_q.reg_write;
	assign rf_waddr     = dec_q.rd;
	assign rf_wdata     = dec_q.is_load ? load_q : result_q.value;
	assign next_pc      = result_q.next_pc;

	assign commit = '{pc: pc_q, inst: inst_q, rd: dec_q.rd, wdata: rf_wdata,
		we: dec_q.reg_write};

endmodule

//--- hdl/rv_regfile.sv
`timescale 1ns/1ps
`include "rv_core_consts.svh"

module rv_regfile (
	input  logic                clock,
	input  logic                rst_n,
	input  logic [3:0]          raddr1,
	input  logic [3:0]          raddr2,
	output logic [`RV_XLEN-1:0] rdata1,
	output logic [`RV_XLEN-1:0] rdata2,
	input  logic                we,
	input  logic [3:0]          waddr,
	input  logic [`RV_XLEN-1:0] wdata
);

	logic [`RV_XLEN-1:0] regs [`RV_NUM_REGS];

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < `RV_NUM_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (we && waddr != 4'd0) begin
			regs[waddr] <= wdata; // x0 stays zero since it is never written.
		end
	end

	assign rdata1 = regs[raddr1];
	assign rdata2 = regs[raddr2];

endmodule

//--- hdl/rv_execute.sv
`timescale 1ns/1ps

module rv_execute (
	input  rv_core_pkg::decoded_t     dec,
	input  logic [31:0]               pc,
	input  logic [31:0]               src1,
	input  logic [31:0]               src2,
	output rv_core_pkg::exec_result_t result
);
	import rv_core_pkg::*;

	logic [31:0] op_b;
	logic [31:0] alu_out;
	logic [31:0] pc_plus4;
	logic [31:0] target;
	logic        equal;
	logic        taken;

	assign op_b = dec.use_imm ? dec.imm : src2;

	always_comb begin
		case (dec.alu)
			ALU_ADD:    alu_out = src1 + op_b;
			ALU_SUB:    alu_out = src1 - op_b;
			ALU_AND:    alu_out = src1 & op_b;
			ALU_OR:     alu_out = src1 | op_b;
			ALU_XOR:    alu_out = src1 ^ op_b;
			ALU_PASS_B: alu_out = op_b;
			default:    alu_out = '0;
		endcase
	end

	assign pc_plus4 = pc + 32'd4;
	assign target   = pc + dec.imm; // branch and jal offsets are both pc relative.
	assign equal    = (src1 == src2);

	always_comb begin
		taken = 1'b0;
		if (!dec.illegal) begin
			if (dec.op == OP_JAL) begin
				taken = 1'b1;
			end else if (dec.op == OP_BRANCH) begin
				taken = equal ^ dec.branch_ne;
			end
		end
	end

	always_comb begin
		result.value    = (dec.op == OP_JAL) ? pc_plus4 : alu_out;
		result.next_pc  = taken ? target : pc_plus4;
		result.mem_addr = src1 + dec.imm;
	end

endmodule

//--- hdl/rv_decode.sv
`timescale 1ns/1ps

module rv_decode (
	input  logic [31:0]           inst,
	output rv_core_pkg::decoded_t dec
);
	import rv_core_pkg::*;

	logic [31:0] imm_i;
	logic [31:0] imm_s;
	logic [31:0] imm_b;
	logic [31:0] imm_u;
	logic [31:0] imm_j;
	logic [2:0]  funct3;
	logic [6:0]  funct7;
	logic        bad_rd;
	logic        bad_rs1;
	logic        bad_rs2;

	assign funct3 = inst[14:12];
	assign funct7 = inst[31:25];

	assign imm_i = {{20{inst[31]}}, inst[31:20]};
	assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
	assign imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
	assign imm_u = {inst[31:12], 12'h000};
	assign imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

	// top bit of each 5-bit register field selects x16..x31, absent in RV32E.
	assign bad_rd  = inst[11];
	assign bad_rs1 = inst[19];
	assign bad_rs2 = inst[24];

	always_comb begin
		dec     = '0;
		dec.op  = OP_IMM;
		dec.alu = ALU_ADD;
		dec.rd  = inst[10:7];
		dec.rs1 = inst[18:15];
		dec.rs2 = inst[23:20];
		case (inst[6:0])
			OP_LUI: begin
				dec.op        = OP_LUI;
				dec.alu       = ALU_PASS_B;
				dec.imm       = imm_u;
				dec.use_imm   = 1'b1;
				dec.reg_write = 1'b1;
				dec.illegal   = bad_rd;
			end
			OP_IMM: begin
				dec.imm       = imm_i;
				dec.use_imm   = 1'b1;
				dec.reg_write = 1'b1;
				dec.illegal   = bad_rd | bad_rs1 | (funct3 != 3'b000); // addi only.
			end
			OP_REG: begin
				dec.op        = OP_REG;
				dec.reg_write = 1'b1;
				dec.illegal   = bad_rd | bad_rs1 | bad_rs2;
				case ({funct7, funct3})
					10'b0000000_000: dec.alu = ALU_ADD;
					10'b0100000_000: dec.alu = ALU_SUB;
					10'b0000000_100: dec.alu = ALU_XOR;
					10'b0000000_110: dec.alu = ALU_OR;
					10'b0000000_111: dec.alu = ALU_AND;
					default:         dec.illegal = 1'b1;
				endcase
			end
			OP_LOAD: begin
				dec.op        = OP_LOAD;
				dec.imm       = imm_i;
				dec.is_load   = 1'b1;
				dec.reg_write = 1'b1;
				dec.illegal   = bad_rd | bad_rs1 | (funct3 != 3'b010);
			end
			OP_STORE: begin
				dec.op       = OP_STORE;
				dec.rd       = 4'd0;
				dec.imm      = imm_s;
				dec.is_store = 1'b1;
				dec.illegal  = bad_rs1 | bad_rs2 | (funct3 != 3'b010);
			end
			OP_BRANCH: begin
				dec.op        = OP_BRANCH;
				dec.rd        = 4'd0;
				dec.imm       = imm_b;
				dec.branch_ne = funct3[0];
				dec.illegal   = bad_rs1 | bad_rs2 | (funct3[2:1] != 2'b00);
			end
			OP_JAL: begin
				dec.op        = OP_JAL;
				dec.imm       = imm_j;
				dec.reg_write = 1'b1;
				dec.illegal   = bad_rd;
			end
			default: begin
				dec.illegal = 1'b1;
			end
		endcase
		if (dec.illegal) begin
			dec.reg_write = 1'b0; // still commits, but touches nothing.
			dec.is_load   = 1'b0;
			dec.is_store  = 1'b0;
		end
	end

endmodule

//--- hdl/rv_fetch.sv
`timescale 1ns/1ps
`include "rv_core_consts.svh"

module rv_fetch (
	input  logic                  clock,
	input  logic                  rst_n,
	input  logic                  commit_valid,
	input  logic [31:0]           next_pc,
	output rv_core_pkg::mem_req_t imem_req,
	output logic                  imem_req_valid,
	input  logic                  imem_req_ready,
	input  logic                  imem_rsp_valid,
	input  logic [31:0]           imem_rsp_data,
	output logic [31:0]           pc,
	output logic [31:0]           inst,
	output logic                  inst_valid
);
	import rv_core_pkg::*;

	core_state_e state;

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			state          <= ST_FETCH;
			pc             <= `RV_RESET_PC;
			imem_req_valid <= 1'b0;
		end else begin
			case (state)
				ST_FETCH: begin
					imem_req_valid <= 1'b1; // only taken once, right after reset.
					state          <= ST_WAIT_INST;
				end
				ST_WAIT_INST: begin
					if (imem_req_valid && imem_req_ready) begin
						imem_req_valid <= 1'b0;
					end
					if (imem_rsp_valid) begin
						state <= ST_EXEC;
					end
				end
				ST_EXEC: begin
					state <= ST_COMMIT;
				end
				ST_COMMIT: begin
					if (commit_valid) begin
						pc             <= next_pc; // next request goes out on the following cycle.
						imem_req_valid <= 1'b1;
						state          <= ST_WAIT_INST;
					end
				end
				default: begin
					state <= ST_FETCH;
				end
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (state == ST_WAIT_INST && imem_rsp_valid) begin
			inst <= imem_rsp_data;
		end
	end

	assign imem_req   = '{addr: pc, wdata: '0, wstrb: 4'h0, write: 1'b0};
	assign inst_valid = (state == ST_EXEC); // one cycle per fetched word.

endmodule

//--- hdl/rv_core_pkg.sv
`include "rv_core_consts.svh"

package rv_core_pkg;

	typedef enum logic [6:0] {
		OP_LUI    = 7'b0110111,
		OP_IMM    = 7'b0010011,
		OP_REG    = 7'b0110011,
		OP_LOAD   = 7'b0000011,
		OP_STORE  = 7'b0100011,
		OP_BRANCH = 7'b1100011,
		OP_JAL    = 7'b1101111
	} opcode_e;

	typedef enum logic [2:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_PASS_B
	} alu_op_e;

	typedef enum logic [2:0] {
		ST_FETCH,
		ST_WAIT_INST,
		ST_EXEC,
		ST_MEM,
		ST_COMMIT
	} core_state_e;

	typedef struct packed {
		logic [`RV_XLEN-1:0] addr;
		logic [`RV_XLEN-1:0] wdata;
		logic [3:0]          wstrb;
		logic                write;
	} mem_req_t;

	typedef struct packed {
		opcode_e             op;
		alu_op_e             alu;
		logic [3:0]          rd;
		logic [3:0]          rs1;
		logic [3:0]          rs2;
		logic [`RV_XLEN-1:0] imm;
		logic                use_imm;
		logic                reg_write;
		logic                is_load;
		logic                is_store;
		logic                branch_ne;
		logic                illegal;
	} decoded_t;

	typedef struct packed {
		logic [`RV_XLEN-1:0] value;
		logic [`RV_XLEN-1:0] next_pc;
		logic [`RV_XLEN-1:0] mem_addr;
	} exec_result_t;

	typedef struct packed {
		logic [`RV_XLEN-1:0] pc;
		logic [`RV_XLEN-1:0] inst;
		logic [3:0]          rd;
		logic [`RV_XLEN-1:0] wdata;
		logic                we;
	} commit_t;

endpackage

//--- include/rv_core_consts.svh
`ifndef RV_CORE_CONSTS_SVH
`define RV_CORE_CONSTS_SVH

// first instruction fetched after reset.
`define RV_RESET_PC 32'h8000_0000

// RV32E keeps only x0..x15.
`define RV_NUM_REGS 16

`define RV_XLEN 32

`endif
